//--- light_grid.f
+incdir+hw
hw/light_cmd_pkg.sv
hw/light_ctrl_pkg.sv
hw/grid_ctrl_if.sv
hw/light_sequencer.sv
hw/grid_bank.sv
hw/intensity_combiner.sv
hw/light_grid.sv
test/light_grid_tb.sv

//--- Bender.yml
package:
  name: light_grid

sources:
  - include_dirs:
      - hw
    files:
      - hw/light_cmd_pkg.sv
      - hw/light_ctrl_pkg.sv
      - hw/grid_ctrl_if.sv
      - hw/light_sequencer.sv
      - hw/grid_bank.sv
      - hw/intensity_combiner.sv
      - hw/light_grid.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/light_grid_tb.sv

//--- test/light_grid_tb.sv
`include "light_grid_params.svh"

module light_grid_tb;

    localparam int DRIVE_DELAY = 2;
    localparam int TIMEOUT = 200;   // Cycles per wait.

    logic clk;
    logic reset;
    logic instr_valid;
    logic instr_last;
    logic [`LG_INSTR_BITS-1:0] instr_data;
    logic instr_ready;
    logic count_done;
    logic [`LG_RESULT_BITS-1:0] count_value;

    int model [`LG_ROWS][`LG_COLS];     // Reference brightness.
    logic [`LG_RESULT_BITS-1:0] expected_total;
    int backpressure_cycles;

    light_grid i_dut (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_last  (instr_last),
        .instr_data  (instr_data),
        .instr_ready (instr_ready),
        .count_done  (count_done),
        .count_value (count_value)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure();
        $display("** FAIL **");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s.", what);
        report_failure();
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    reset_state: assert property (@(posedge clk)
        (reset ##1 reset) |-> (!instr_ready && !count_done && count_value == '0))
    else begin
        $display("Mismatch after reset: instr_ready 0x%h count_done 0x%h count_value 0x%h",
                 instr_ready, count_done, count_value);
        report_failure();
    end

    batch_total: assert property (@(posedge clk) disable iff (reset)
        $rose(count_done) |-> (count_value == expected_total))
    else begin
        $display("Mismatch count_value: got 0x%h expected 0x%h", count_value, expected_total);
        report_failure();
    end

    new_batch_clears: assert property (@(posedge clk) disable iff (reset)
        (instr_valid && instr_ready && count_done) |=> (!count_done && count_value == '0))
    else begin
        $display("Mismatch on new batch: count_done 0x%h count_value 0x%h expected 0x0",
                 count_done, count_value);
        report_failure();
    end

    one_in_flight: assert property (@(posedge clk) disable iff (reset)
        (instr_valid && instr_ready) |=> !instr_ready)
    else begin
        $display("Mismatch instr_ready after accept: got 0x%h expected 0x0", instr_ready);
        report_failure();
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic int next_brightness(input logic [1:0] op, input int light);
        case (op)
            light_cmd_pkg::turn_on:  return light + 1;
            light_cmd_pkg::toggle:   return light + 2;
            light_cmd_pkg::turn_off: return (light > 0) ? light - 1 : 0;
            default:                 return light;
        endcase
    endfunction

    task automatic apply_to_model(input logic [1:0] op, input int sr, input int sc,
                                  input int er, input int ec);
        for (int r = sr; r <= er; r++) begin
            for (int c = sc; c <= ec; c++) begin
                model[r][c] = next_brightness(op, model[r][c]);
            end
        end
    endtask

    function automatic int model_total();
        int sum;
        sum = 0;
        for (int r = 0; r < `LG_ROWS; r++) begin
            for (int c = 0; c < `LG_COLS; c++) begin
                sum += model[r][c];
            end
        end
        return sum;
    endfunction

    task automatic clear_model();
        for (int r = 0; r < `LG_ROWS; r++) begin
            for (int c = 0; c < `LG_COLS; c++) begin
                model[r][c] = 0;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Valid stays high until the DUT takes the command.
    task automatic send_cmd(input logic [1:0] op, input int sr, input int sc,
                            input int er, input int ec, input logic last);
        light_cmd_pkg::cmd_s cmd;
        int waited;
        cmd.op = light_cmd_pkg::op_e'(op);
        cmd.start_row = `LG_POS_BITS'(sr);
        cmd.start_col = `LG_POS_BITS'(sc);
        cmd.end_row = `LG_POS_BITS'(er);
        cmd.end_col = `LG_POS_BITS'(ec);
        instr_data = cmd;
        instr_last = last;
        instr_valid = 1'b1;
        waited = 0;
        while (!instr_ready) begin
            backpressure_cycles++;
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("instr_ready");
            end
        end
        @(posedge clk);     // Accepted here.
        #DRIVE_DELAY;
        instr_valid = 1'b0;
        apply_to_model(op, sr, sc, er, ec);
    endtask

    task automatic finish_batch();
        int waited;
        expected_total = `LG_RESULT_BITS'(model_total());
        waited = 0;
        while (!count_done) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("count_done");
            end
        end
        @(posedge clk);     // Result check samples the rise here.
        #DRIVE_DELAY;
        clear_model();
    endtask

    task automatic random_batch(input int count);
        int r0;
        int r1;
        int c0;
        int c1;
        logic [1:0] op;
        for (int i = 0; i < count; i++) begin
            op = 2'($urandom % 4);
            r0 = int'($urandom % `LG_ROWS);
            r1 = int'($urandom % `LG_ROWS);
            c0 = int'($urandom % `LG_COLS);
            c1 = int'($urandom % `LG_COLS);
            send_cmd(op, (r0 < r1) ? r0 : r1, (c0 < c1) ? c0 : c1,
                     (r0 < r1) ? r1 : r0, (c0 < c1) ? c1 : c0, i == count - 1);
        end
    endtask

    initial begin
        void'($urandom(32'hb1f6c259));
        reset = 1'b1;
        instr_valid = 1'b0;
        instr_last = 1'b0;
        instr_data = '0;
        backpressure_cycles = 0;
        expected_total = '0;
        clear_model();
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // Rectangles across the bank boundary.
        send_cmd(light_cmd_pkg::turn_on, 0, 5, 3, 10, 1'b0);
        send_cmd(light_cmd_pkg::turn_on, 2, 0, 15, 15, 1'b0);
        send_cmd(light_cmd_pkg::turn_on, 7, 7, 9, 8, 1'b1);
        finish_batch();

        // Lit square then turn_off and reserved over lit and dark lights.
        send_cmd(light_cmd_pkg::toggle, 4, 4, 11, 11, 1'b0);
        send_cmd(light_cmd_pkg::turn_off, 0, 0, 15, 15, 1'b0);
        send_cmd(light_cmd_pkg::reserved, 0, 0, 15, 15, 1'b0);
        send_cmd(light_cmd_pkg::turn_off, 2, 6, 13, 9, 1'b0);
        send_cmd(light_cmd_pkg::turn_off, 0, 0, 3, 15, 1'b1);
        finish_batch();

        random_batch(20 + int'($urandom % 21));
        finish_batch();

        send_cmd(light_cmd_pkg::turn_on, 15, 15, 15, 15, 1'b1);
        finish_batch();

        if (backpressure_cycles == 0) begin
            $display("No command was ever held against a busy DUT.");
            report_failure();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- hw/light_grid.sv
`include "light_grid_params.svh"

module light_grid (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instr_valid,
    input  logic                       instr_last,
    input  logic [`LG_INSTR_BITS-1:0]  instr_data,
    output logic                       instr_ready,
    output logic                       count_done,
    output logic [`LG_RESULT_BITS-1:0] count_value
);

    logic combine_en;
    logic result_clr;
    logic [`LG_RESULT_BITS-1:0] sum_lo;
    logic [`LG_RESULT_BITS-1:0] sum_hi;

    grid_ctrl_if ctrl ();

    light_sequencer i_sequencer (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_last  (instr_last),
        .instr_data  (instr_data),
        .instr_ready (instr_ready),
        .count_done  (count_done),
        .combine_en  (combine_en),
        .result_clr  (result_clr),
        .ctrl        (ctrl.seq)
    );

    // Left and right column halves.
    grid_bank #(.BASE_COL(0)) i_bank_lo (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl.bank),
        .bank_sum (sum_lo)
    );

    grid_bank #(.BASE_COL(`LG_BANK_COLS)) i_bank_hi (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl.bank),
        .bank_sum (sum_hi)
    );

    intensity_combiner i_combiner (
        .clk         (clk),
        .reset       (reset),
        .combine_en  (combine_en),
        .result_clr  (result_clr),
        .sum_a       (sum_lo),
        .sum_b       (sum_hi),
        .count_value (count_value)
    );

endmodule

//--- hw/intensity_combiner.sv
`include "light_grid_params.svh"

module intensity_combiner (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       combine_en,
    input  logic                       result_clr,
    input  logic [`LG_RESULT_BITS-1:0] sum_a,
    input  logic [`LG_RESULT_BITS-1:0] sum_b,
    output logic [`LG_RESULT_BITS-1:0] count_value
);

    logic [`LG_RESULT_BITS-1:0] total;

    assign total = sum_a + sum_b;   // Stimulus keeps this in range.

    // Held until the next batch starts.
    always_ff @(posedge clk) begin
        if (reset) begin
            count_value <= '0;
        end else if (result_clr) begin
            count_value <= '0;
        end else if (combine_en) begin
            count_value <= total;
        end
    end

endmodule

//--- hw/grid_bank.sv
`include "light_grid_params.svh"

module grid_bank #(
    parameter int BASE_COL = 0
) (
    input  logic                       clk,
    input  logic                       reset,
    grid_ctrl_if.bank                  ctrl,
    output logic [`LG_RESULT_BITS-1:0] bank_sum
);

    localparam int LB = `LG_LIGHT_BITS;
    localparam int ROW_BITS = `LG_BANK_COLS * LB;

    logic [ROW_BITS-1:0] mem [`LG_ROWS];
    logic [ROW_BITS-1:0] rd_data;
    logic [ROW_BITS-1:0] row_upd;
    logic [ROW_BITS-1:0] wr_data;
    logic [`LG_RESULT_BITS-1:0] row_total;

    function automatic logic [LB-1:0] apply_op(
        input light_cmd_pkg::op_e op,
        input logic [LB-1:0]      light
    );
        case (op)
            light_cmd_pkg::turn_on:  apply_op = light + 1'b1;
            light_cmd_pkg::turn_off: apply_op = (light != '0) ? light - 1'b1 : light;
            light_cmd_pkg::toggle:   apply_op = light + 2'd2;
            default:                 apply_op = light;  // Reserved.
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Row RAM, one read and one write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        rd_data <= mem[ctrl.rd_row];
    end

    always_ff @(posedge clk) begin
        if (ctrl.we) begin
            mem[ctrl.wr_row] <= ctrl.clear ? '0 : wr_data;
        end
    end

    // Per column update.
    for (genvar j = 0; j < `LG_BANK_COLS; j++) begin : g_col
        localparam int COL = BASE_COL + j;

        logic [LB-1:0] light;
        logic in_range;

        assign light = rd_data[j*LB +: LB];
        assign in_range = (int'(ctrl.cmd.start_col) <= COL) && (COL <= int'(ctrl.cmd.end_col));
        assign row_upd[j*LB +: LB] = in_range ? apply_op(ctrl.cmd.op, light) : light;
    end

    always_ff @(posedge clk) begin
        wr_data <= row_upd;     // Written one cycle later.
    end

    // Row sum and accumulator.
    always_comb begin
        row_total = '0;
        for (int j = 0; j < `LG_BANK_COLS; j++) begin
            row_total = row_total + `LG_RESULT_BITS'(rd_data[j*LB +: LB]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl.sum_clr) begin
            bank_sum <= '0;
        end else if (ctrl.sum_en) begin
            bank_sum <= bank_sum + row_total;
        end
    end

endmodule

//--- hw/light_sequencer.sv
`include "light_grid_params.svh"

module light_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      instr_valid,
    input  logic                      instr_last,
    input  logic [`LG_INSTR_BITS-1:0] instr_data,
    output logic                      instr_ready,
    output logic                      count_done,
    output logic                      combine_en,
    output logic                      result_clr,
    grid_ctrl_if.seq                  ctrl
);

    localparam int LAT = `LG_UPDATE_LATENCY;
    localparam int RD_STAGE = 0;
    localparam int DATA_STAGE = 1;
    localparam int WR_STAGE = LAT - 1;
    localparam logic [`LG_POS_BITS-1:0] LAST_ROW = `LG_POS_BITS'(`LG_ROWS - 1);

    light_ctrl_pkg::seq_state_e state;
    light_ctrl_pkg::seq_state_e state_nxt;
    light_cmd_pkg::cmd_s cmd_q;
    logic last_q;
    logic accept;
    logic rows_done;
    logic sum_done;
    logic clear_last;
    logic [LAT-1:0][`LG_POS_BITS-1:0] row_sr;   // Stage 0 is the read row.
    logic [LAT-1:0] we_sr;
    logic [LAT-1:0] sum_sr;

    assign accept = instr_valid && instr_ready;
    assign rows_done = we_sr[WR_STAGE] && (row_sr[WR_STAGE] == cmd_q.end_row);
    assign sum_done = sum_sr[WR_STAGE] && (row_sr[WR_STAGE] == LAST_ROW);
    assign clear_last = we_sr[WR_STAGE] && (row_sr[WR_STAGE] == LAST_ROW);

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= light_ctrl_pkg::clear_sweep;   // Wipe the grid first.
            instr_ready <= 1'b0;
        end else begin
            state <= state_nxt;
            instr_ready <= (state_nxt == light_ctrl_pkg::idle_ready);
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            light_ctrl_pkg::idle_ready: begin
                if (accept) begin
                    state_nxt = light_ctrl_pkg::capture;
                end
            end
            light_ctrl_pkg::capture: state_nxt = light_ctrl_pkg::update_rows;
            light_ctrl_pkg::update_rows: begin
                if (rows_done) begin
                    state_nxt = last_q ? light_ctrl_pkg::sum_sweep : light_ctrl_pkg::idle_ready;
                end
            end
            light_ctrl_pkg::sum_sweep: begin
                if (sum_done) begin
                    state_nxt = light_ctrl_pkg::combine;
                end
            end
            light_ctrl_pkg::combine: state_nxt = light_ctrl_pkg::clear_sweep;
            light_ctrl_pkg::clear_sweep: begin
                if (clear_last) begin
                    state_nxt = last_q ? light_ctrl_pkg::done : light_ctrl_pkg::idle_ready;
                end
            end
            default: state_nxt = light_ctrl_pkg::idle_ready;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= light_cmd_pkg::cmd_s'(instr_data);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_q <= 1'b0;
            count_done <= 1'b0;
        end else if (accept) begin
            last_q <= instr_last;
            count_done <= 1'b0;
        end else if (state == light_ctrl_pkg::done) begin
            count_done <= 1'b1;    // Rises with instr_ready.
        end
    end

    //////////////////////////////////////////////////
    // Row pointer pipeline
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            row_sr <= '0;
            we_sr <= '0;
            sum_sr <= '0;
        end else begin
            row_sr <= {row_sr[LAT-2:0], row_sr[RD_STAGE] + 1'b1};
            we_sr <= {we_sr[LAT-2:0], 1'b0};
            sum_sr <= {sum_sr[LAT-2:0], 1'b0};
            case (state)
                light_ctrl_pkg::capture: begin
                    row_sr[RD_STAGE] <= cmd_q.start_row;
                    we_sr[RD_STAGE] <= 1'b1;
                end
                light_ctrl_pkg::update_rows: begin
                    we_sr[RD_STAGE] <= we_sr[RD_STAGE] && (row_sr[RD_STAGE] != cmd_q.end_row);
                end
                light_ctrl_pkg::sum_sweep: begin
                    if (sum_sr == '0) begin     // Pipeline empty on entry.
                        row_sr[RD_STAGE] <= '0;
                        sum_sr[RD_STAGE] <= 1'b1;
                    end else begin
                        sum_sr[RD_STAGE] <= sum_sr[RD_STAGE] && (row_sr[RD_STAGE] != LAST_ROW);
                    end
                end
                light_ctrl_pkg::combine: begin
                    row_sr[WR_STAGE] <= '0;
                    we_sr[WR_STAGE] <= 1'b1;
                end
                light_ctrl_pkg::clear_sweep: begin
                    // Clear drives the write stage directly.
                    row_sr[WR_STAGE] <= we_sr[WR_STAGE] ? row_sr[WR_STAGE] + 1'b1 : '0;
                    we_sr[WR_STAGE] <= !clear_last;
                end
                default: begin
                end
            endcase
        end
    end

    assign combine_en = (state == light_ctrl_pkg::combine);
    assign result_clr = accept && count_done;

    assign ctrl.cmd = cmd_q;
    assign ctrl.rd_row = row_sr[RD_STAGE];
    assign ctrl.wr_row = row_sr[WR_STAGE];
    assign ctrl.we = we_sr[WR_STAGE];
    assign ctrl.clear = (state == light_ctrl_pkg::clear_sweep);
    assign ctrl.sum_en = sum_sr[DATA_STAGE];    // Read data valid.
    assign ctrl.sum_clr = (state == light_ctrl_pkg::clear_sweep);

endmodule

//--- hw/grid_ctrl_if.sv
`include "light_grid_params.svh"

// Sequencer to bank control, shared by both banks.
interface grid_ctrl_if;

    light_cmd_pkg::cmd_s cmd;
    logic [`LG_POS_BITS-1:0] rd_row;
    logic [`LG_POS_BITS-1:0] wr_row;
    logic we;
    logic clear;        // Write zeros.
    logic sum_en;       // Accumulate the row read data.
    logic sum_clr;

    modport seq (
        output cmd,
        output rd_row,
        output wr_row,
        output we,
        output clear,
        output sum_en,
        output sum_clr
    );

    modport bank (
        input cmd,
        input rd_row,
        input wr_row,
        input we,
        input clear,
        input sum_en,
        input sum_clr
    );

endinterface

//--- hw/light_ctrl_pkg.sv
package light_ctrl_pkg;

    // Sequencer FSM.
    typedef enum logic [2:0] {
        idle_ready,     // Waiting for a command.
        capture,
        update_rows,
        sum_sweep,
        combine,
        clear_sweep,
        done
    } seq_state_e;

endpackage

//--- hw/light_cmd_pkg.sv
`include "light_grid_params.svh"

package light_cmd_pkg;

    // Opcode encoding of the instruction word.
    typedef enum logic [1:0] {
        turn_off = 2'b00,
        toggle   = 2'b01,
        reserved = 2'b10,
        turn_on  = 2'b11
    } op_e;

    typedef logic [`LG_POS_BITS-1:0] pos_t;

    // Rectangle command, opcode in the top bits.
    typedef struct packed {
        op_e  op;
        pos_t start_row;
        pos_t start_col;
        pos_t end_row;
        pos_t end_col;
    } cmd_s;

endpackage

//--- hw/light_grid_params.svh
`ifndef LIGHT_GRID_PARAMS_SVH
`define LIGHT_GRID_PARAMS_SVH

//////////////////////////////////////////////////
// Grid geometry
//////////////////////////////////////////////////

`define LG_ROWS 16
`define LG_COLS 16
`define LG_BANK_COLS 8      // Columns held by one bank.

// Row or column coordinate.
`define LG_POS_BITS 4

//////////////////////////////////////////////////
// Data widths
//////////////////////////////////////////////////

`define LG_LIGHT_BITS 8
`define LG_RESULT_BITS 16
`define LG_INSTR_BITS 18    // Opcode plus four coordinates.

// Read, modify, write.
`define LG_UPDATE_LATENCY 3

`endif
